/* src.f */
cpuOpcodePkg.sv
cpuUopPkg.sv
ucodeLut.sv
ucodeRom.sv
uopSequencer.sv
cpuDatapath.sv
gbCpuCore.sv
tbChecker.sv
tbGbCpu.sv

/* run.sh */
#!/bin/bash
# Build with Verilator, run, then decide on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tbGbCpu -f src.f -o simGbCpu \
	> build.log 2>&1 \
	&& ./obj_dir/simGbCpu > sim.log 2>&1 \
	|| { echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL: no result line"; exit 1; }

/* tbGbCpu.sv */
`timescale 1ns/10ps

module tbGbCpu
	import cpuOpcodePkg::*;
	import cpuUopPkg::*;
();

	// Taken JR is the longest flow
	localparam int maxFlowLen = 6;
	localparam int clkPeriod = 8;
	localparam int slotCount = 150;

	logic clock;
	logic rst;
	logic [7:0] rData;
	memBus_t memBus;
	memBus_t busQ;
	logic fetch;
	logic done;
	logic genDone;
	int valueErrs;
	int otherErrs;
	int instrCount;
	int limitNs;
	logic [15:0] loopAddr;
	logic [15:0] wp;
	logic [31:0] seed;
	logic [7:0] mem [65536];

	always #(clkPeriod / 2) clock = ~clock;

	gbCpuCore gbCpuCore_inst
	(
		.clock(clock),
		.rst(rst),
		.rData(rData),
		.memBus(memBus),
		.fetch(fetch)
	);

	tbChecker tbChecker_inst
	(
		.clock(clock),
		.rst(rst),
		.fetch(fetch),
		.memBus(memBus),
		.image(mem),
		.loopAddr(loopAddr),
		.done(done),
		.valueErrs(valueErrs),
		.otherErrs(otherErrs)
	);

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////

	// Bus taken mid-cycle
	always @(negedge clock)
		busQ <= memBus;

	// Synchronous read, old data on a same-address write
	always @(posedge clock)
	begin
		logic [7:0] rdVal;
		rdVal = mem[busQ.addr];
		if (busQ.wEn)
			mem[busQ.addr] = busQ.wData;
		#1;
		rData = rdVal;
	end

	////////////////////////////////////////
	// Program generator
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Random value below n
	function automatic int unsigned rnd(input int unsigned n);
		seed = xorshift(seed);
		return seed % n;
	endfunction

	task automatic emit(input logic [7:0] b);
		mem[wp] = b;
		wp = wp + 16'd1;
	endtask

	// Opcode register code, 6 would be (HL)
	function automatic logic [2:0] pickReg();
		int unsigned v;
		v = rnd(7);
		return (v == 6) ? 3'd7 : 3'(v);
	endfunction

	task automatic emitLdRn(input logic [2:0] r);
		logic [7:0] v;
		v = 8'(rnd(256));
		// H kept in the data region well above the program
		if (r == 3'd4)
			v = 8'h40 + 8'(rnd(128));
		emit({2'b00, r, 3'b110});
		emit(v);
		instrCount++;
	endtask

	// One-byte INC, DEC, ADD or SUB
	task automatic emitAlu1();
		logic [2:0] r;
		r = pickReg();
		case (rnd(4))
			0: emit({2'b00, r, 3'b100});
			1: emit({2'b00, r, 3'b101});
			2: emit({5'b10000, r});
			default: emit({5'b10010, r});
		endcase
		instrCount++;
	endtask

	task automatic emitUnknown();
		logic [7:0] b;
		case (rnd(8))
			0: b = 8'h01;
			1: b = 8'h10;
			2: b = 8'h2F;
			3: b = 8'h34;
			4: b = 8'h36;
			5: b = 8'h76;
			6: b = 8'hA8;
			default: b = 8'hFF;
		endcase
		emit(b);
		// Sometimes an unknown CB opcode instead
		if (rnd(4) == 0)
		begin
			b = 8'(rnd(256));
			if (b == opBit7H)
				b = 8'h7D;
			emit(b);
			mem[wp - 16'd2] = opPrefixCb;
		end
		instrCount++;
	endtask

	task automatic buildProgram();
		logic [15:0] target;
		int gap;
		// Fill touches every address bit
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 3) ^ 8'hA5;
		wp = 16'h0000;
		instrCount = 0;
		// Known values in every register first
		emitLdRn(3'd7);
		for (int r = 0; r < 6; r++)
			emitLdRn(3'(r));
		for (int s = 0; s < slotCount; s++)
		begin
			if (s % 5 == 4)
			begin
				emit(opLdHlA);
				instrCount++;
			end
			else
			begin
				case (rnd(12))
					0, 1: emitLdRn(pickReg());
					2, 3, 4: emitAlu1();
					5:
					begin
						emit(opLdHlNn);
						emit(8'(rnd(256)));
						emit(8'h40 + 8'(rnd(128)));
						instrCount++;
					end
					6:
					begin
						emit(opLdAHl);
						instrCount++;
					end
					7:
					begin
						// Conditional hop over one ALU byte
						if (rnd(2) == 0)
							emit(opJrNz);
						else
							emit(opJrZ);
						emit(8'h01);
						instrCount++;
						emitAlu1();
					end
					8:
					begin
						emit(opPrefixCb);
						emit(opBit7H);
						instrCount++;
					end
					9:
					begin
						// Forward jump over a few junk bytes
						gap = int'(rnd(4));
						target = wp + 16'd3 + 16'(gap);
						emit(opJpNn);
						emit(target[7:0]);
						emit(target[15:8]);
						instrCount++;
						for (int g = 0; g < gap; g++)
							emit(8'(rnd(256)));
					end
					10:
					begin
						// Forward, back by 4, forward again
						emit(opJr);
						emit(8'h02);
						emit(opJr);
						emit(8'h02);
						emit(opJr);
						emit(8'hFC);
						instrCount += 3;
					end
					default: emitUnknown();
				endcase
			end
		end
		// Final spin, JR -2
		loopAddr = wp;
		emit(opJr);
		emit(8'hFE);
		instrCount++;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		clock = 1'b0;
		rst = 1'b1;
		rData = 8'h00;
		busQ = '0;
		genDone = 1'b0;
		seed = 32'haa93_139e;
		buildProgram();
		limitNs = (instrCount * maxFlowLen + 100) * clkPeriod;
		genDone = 1'b1;
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;
		wait (done);
		// Let the last stores drain
		repeat (4) @(posedge clock);
		$display("Error counts: %0d value mismatches, %0d other failures", valueErrs,
			otherErrs);
		if (valueErrs == 0 && otherErrs == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (genDone);
		#(limitNs);
		$display("Watchdog: program did not reach its end loop within %0d ns", limitNs);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* tbChecker.sv */
`timescale 1ns/10ps

module tbChecker
	import cpuOpcodePkg::*;
	import cpuUopPkg::*;
(
	input logic clock,
	input logic rst,
	input logic fetch,
	input memBus_t memBus,
	input logic [7:0] image [65536],
	input logic [15:0] loopAddr,
	output logic done,
	output int valueErrs,
	output int otherErrs
);

	// Model registers indexed by the 3-bit opcode code
	// B C D E H L (HL) A
	logic [7:0] mm [65536];
	logic [7:0] rf [8];
	logic [15:0] mPc;
	logic mZ;
	logic [15:0] prevAddr;

	// Stores the model has done and the bus has not shown yet
	logic [15:0] expAddr [$];
	logic [7:0] expData [$];
	logic [15:0] wantAddr;
	logic [7:0] wantData;

	initial
	begin
		valueErrs = 0;
		otherErrs = 0;
		done = 1'b0;
		prevAddr = 16'h0000;
	end

	////////////////////////////////////////
	// One instruction of the model
	////////////////////////////////////////

	task automatic execOne();
		logic [7:0] opc;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [2:0] rd;
		logic [2:0] rs;
		logic [7:0] res;
		logic [15:0] hl;
		opc = mm[mPc];
		b1 = mm[mPc + 16'd1];
		b2 = mm[mPc + 16'd2];
		rd = opc[5:3];
		rs = opc[2:0];
		hl = {rf[4], rf[5]};
		if (opc == opLdHlNn)
		begin
			// Little endian immediate
			rf[5] = b1;
			rf[4] = b2;
			mPc = mPc + 16'd3;
		end
		else if (opc == opLdHlA)
		begin
			mm[hl] = rf[7];
			expAddr.push_back(hl);
			expData.push_back(rf[7]);
			mPc = mPc + 16'd1;
		end
		else if (opc == opLdAHl)
		begin
			rf[7] = mm[hl];
			mPc = mPc + 16'd1;
		end
		else if (opc == opJr || (opc == opJrNz && !mZ) || (opc == opJrZ && mZ))
			// Offset counts from the byte after the instruction
			mPc = mPc + 16'd2 + {{8{b1[7]}}, b1};
		else if (opc == opJrNz || opc == opJrZ)
			mPc = mPc + 16'd2;
		else if (opc == opJpNn)
			mPc = {b2, b1};
		else if (opc == opPrefixCb)
		begin
			// Any other second byte is a two-byte NOP
			if (b1 == opBit7H)
				mZ = !rf[4][7];
			mPc = mPc + 16'd2;
		end
		else if (opc[7:6] == 2'b00 && opc[2:0] == 3'b110 && rd != 3'd6)
		begin
			rf[rd] = b1;
			mPc = mPc + 16'd2;
		end
		else if (opc[7:6] == 2'b00 && opc[2:1] == 2'b10 && rd != 3'd6)
		begin
			// INC with bit 0 clear, DEC with it set
			rf[rd] = opc[0] ? rf[rd] - 8'd1 : rf[rd] + 8'd1;
			mZ = (rf[rd] == 8'h00);
			mPc = mPc + 16'd1;
		end
		else if ((opc[7:3] == 5'b10000 || opc[7:3] == 5'b10010) && rs != 3'd6)
		begin
			// Bit 4 picks SUB over ADD
			if (opc[4])
				res = rf[7] - rf[rs];
			else
				res = rf[7] + rf[rs];
			rf[7] = res;
			mZ = (res == 8'h00);
			mPc = mPc + 16'd1;
		end
		else
			// NOP and every unknown opcode
			mPc = mPc + 16'd1;
	endtask

	////////////////////////////////////////
	// Bus watch at mid-cycle
	////////////////////////////////////////

	always @(negedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < 65536; i++)
				mm[i] = image[i];
			mPc = 16'h0000;
			mZ = 1'b0;
			done = 1'b0;
			expAddr.delete();
			expData.delete();
		end
		else
		begin
			if (memBus.wEn)
			begin
				if (expAddr.size() == 0)
				begin
					otherErrs++;
					$display("%0t: bus write to %h while no store was due", $time,
						memBus.addr);
				end
				else
				begin
					wantAddr = expAddr.pop_front();
					wantData = expData.pop_front();
					if (memBus.addr !== wantAddr)
					begin
						valueErrs++;
						$display("[FAIL] %0t memBus.addr: got %h, expected %h", $time,
							memBus.addr, wantAddr);
					end
					if (memBus.wData !== wantData)
					begin
						valueErrs++;
						$display("[FAIL] %0t memBus.wData: got %h, expected %h", $time,
							memBus.wData, wantData);
					end
				end
			end
			if (fetch)
			begin
				// Store of the last instruction never reached the bus
				if (expAddr.size() != 0)
				begin
					otherErrs++;
					$display("%0t: store to %h missing before the next fetch", $time,
						expAddr[0]);
					expAddr.delete();
					expData.delete();
				end
				// Opcode address is the one the memory registered last cycle
				if (prevAddr !== mPc)
				begin
					valueErrs++;
					$display("[FAIL] %0t fetch address: got %h, expected %h", $time,
						prevAddr, mPc);
				end
				if (mPc == loopAddr)
					done = 1'b1;
				execOne();
			end
		end
		prevAddr = memBus.addr;
	end

endmodule

/* gbCpuCore.sv */
`timescale 1ns/10ps

module gbCpuCore
	import cpuUopPkg::*;
(
	input logic clock,
	input logic rst,
	input logic [7:0] rData,
	output memBus_t memBus,
	output logic fetch
);

	logic [uopAddrW-1:0] uPc;
	uop_t uop;
	logic zFlag;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	uopSequencer uopSequencer_inst
	(
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.rData(rData),
		.zFlag(zFlag),
		.uPc(uPc),
		.fetch(fetch)
	);

	// Combinational, word valid in the same cycle
	ucodeRom ucodeRom_inst
	(
		.uAddr(uPc),
		.uop(uop)
	);

	////////////////////////////////////////
	// Registers and bus
	////////////////////////////////////////

	cpuDatapath cpuDatapath_inst
	(
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.rData(rData),
		.memBus(memBus),
		.zFlag(zFlag)
	);

endmodule

/* cpuDatapath.sv */
`timescale 1ns/10ps

module cpuDatapath
	import cpuUopPkg::*;
(
	input logic clock,
	input logic rst,
	input uop_t uop,
	input logic [7:0] rData,
	output memBus_t memBus,
	output logic zFlag
);

	// A B C D E H L indexed by the low bits of regSel_t
	logic [7:0] regFile [7];
	logic [15:0] pcReg;
	logic [15:0] addrReg;
	logic [15:0] x16Reg;
	logic [7:0] x8Reg;
	logic zReg;
	logic cReg;

	logic [2:0] regIdx;
	logic isReg8;
	logic pcInc;
	logic [15:0] srcVal;
	logic [15:0] pcNext;
	logic [15:0] addr;
	logic [15:0] aluOperand;
	logic [15:0] aluRes;
	logic [15:0] stepRes;
	logic [15:0] wbVal;
	logic wbEn;

	assign regIdx = uop.sel[2:0];
	assign isReg8 = uop.sel inside {a, b, c, d, e, h, l};
	assign pcInc = uop.act inside {inc, incEof, incEofZ, incEofNz};

	////////////////////////////////////////
	// Operand read
	////////////////////////////////////////

	always_comb
	begin
		case (uop.sel)
			a, b, c, d, e, h, l: srcVal = {8'h00, regFile[regIdx]};
			hl: srcVal = {regFile[3'(h)], regFile[3'(l)]};
			de: srcVal = {regFile[3'(d)], regFile[3'(e)]};
			pc: srcVal = pcReg;
			x8: srcVal = {8'h00, x8Reg};
			x16: srcVal = x16Reg;
			default: srcVal = 16'h0000;
		endcase
	end

	// Relative jump offset is signed, register operands are not
	assign aluOperand = (uop.sel == x8) ? {{8{x8Reg[7]}}, x8Reg} : srcVal;
	assign aluRes = (uop.oper == subx16) ? x16Reg - aluOperand : x16Reg + aluOperand;
	assign stepRes = (uop.oper == dec16) ? srcVal - 1'b1 : srcVal + 1'b1;

	////////////////////////////////////////
	// PC and memory bus
	////////////////////////////////////////

	assign pcNext = (uop.oper == spc) ? srcVal : (pcInc ? pcReg + 1'b1 : pcReg);

	// Bus follows PC whenever it moves, otherwise holds the last address
	always_comb
	begin
		if (uop.oper == sma)
			addr = srcVal;
		else if (pcInc || uop.oper == spc)
			addr = pcNext;
		else
			addr = addrReg;
	end

	assign memBus.addr = addr;
	assign memBus.wData = srcVal[7:0];
	assign memBus.wEn = (uop.oper == smw);
	assign zFlag = zReg;

	// Write-back value for register destinations
	always_comb
	begin
		wbEn = uop.oper inside {srm, srx16, inc16, dec16};
		case (uop.oper)
			srm: wbVal = {8'h00, rData};
			srx16: wbVal = x16Reg;
			inc16, dec16: wbVal = stepRes;
			default: wbVal = srcVal;
		endcase
	end

	////////////////////////////////////////
	// State update
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			pcReg <= '0;
			addrReg <= '0;
			zReg <= 1'b0;
			cReg <= 1'b0;
		end
		else
		begin
			pcReg <= pcNext;
			addrReg <= addr;
			if (wbEn)
			begin
				case (uop.sel)
					hl:
					begin
						regFile[3'(h)] <= wbVal[15:8];
						regFile[3'(l)] <= wbVal[7:0];
					end
					de:
					begin
						regFile[3'(d)] <= wbVal[15:8];
						regFile[3'(e)] <= wbVal[7:0];
					end
					x8: x8Reg <= wbVal[7:0];
					// Low byte arrives first and shifts down from the top
					x16: x16Reg <= (uop.oper == srm) ? {rData, x16Reg[15:8]} : wbVal;
					default:
						if (isReg8)
							regFile[regIdx] <= wbVal[7:0];
				endcase
			end
			case (uop.oper)
				sx16r: x16Reg <= srcVal;
				addx16, subx16:
				begin
					x16Reg <= aluRes;
					// Flags only for ADD and SUB and never for jump offsets
					if (isReg8)
					begin
						zReg <= (aluRes[7:0] == 8'h00);
						cReg <= aluRes[8];
					end
				end
				inc16, dec16:
					if (isReg8)
						zReg <= (stepRes[7:0] == 8'h00);
				// Z set when the tested bit is clear
				bitTest: zReg <= ~srcVal[7];
				default: ;
			endcase
		end
	end

endmodule

/* uopSequencer.sv */
`timescale 1ns/10ps

module uopSequencer
	import cpuUopPkg::*;
(
	input logic clock,
	input logic rst,
	input uop_t uop,
	input logic [7:0] rData,
	input logic zFlag,
	output logic [uopAddrW-1:0] uPc,
	output logic fetch
);

	// Wait covers the memory latency after reset
	typedef enum logic [1:0]
	{
		sWait,
		sFetch,
		sRun,
		sCb
	} seqState_t;

	seqState_t state;
	logic [uopAddrW-1:0] uPcReg;
	logic [7:0] opLatch;
	logic [7:0] mop;
	logic [7:0] flowIdx;
	logic endFlow;

	// Opcode straight from memory in fetch, latched byte afterwards
	assign mop = (state == sFetch) ? rData : opLatch;

	ucodeLut ucodeLut_inst
	(
		.mop(mop),
		.cbMode(state == sCb),
		.flowIdx(flowIdx)
	);

	////////////////////////////////////////
	// Micro-PC select
	////////////////////////////////////////

	// First micro-op of a flow runs in the lookup cycle itself
	always_comb
	begin
		case (state)
			sWait: uPc = uPcIdle;
			sFetch: uPc = flowIdx;
			sCb: uPc = flowIdx;
			default: uPc = uPcReg;
		endcase
	end

	// Conditional ends look at Z from the previous instruction
	always_comb
	begin
		case (uop.act)
			eof: endFlow = 1'b1;
			incEof: endFlow = 1'b1;
			incEofZ: endFlow = zFlag;
			incEofNz: endFlow = !zFlag;
			default: endFlow = 1'b0;
		endcase
	end

	assign fetch = (state == sFetch);

	////////////////////////////////////////
	// State update
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= sWait;
			uPcReg <= '0;
		end
		else
		begin
			uPcReg <= uPc + 1'b1;
			if (state == sFetch)
				opLatch <= rData;
			if (state == sWait)
				state <= sFetch;
			else if (endFlow)
				state <= sFetch;
			else if (uop.act == jumpCb)
			begin
				// Byte after the prefix is on rData now
				opLatch <= rData;
				state <= sCb;
			end
			else
				state <= sRun;
		end
	end

endmodule

/* ucodeRom.sv */
`timescale 1ns/10ps

module ucodeRom
	import cpuOpcodePkg::*;
	import cpuUopPkg::*;
(
	input logic [uopAddrW-1:0] uAddr,
	output uop_t uop
);

	// Packs one ROM word
	function automatic uop_t mkUop(seqAct_t act, uopOp_t oper, regSel_t sel);
		uop_t w;
		w.act = act;
		w.oper = oper;
		w.sel = sel;
		return w;
	endfunction

	always_comb
	begin
		logic [7:0] off;
		regSel_t fReg;
		off = 8'd0;
		fReg = none;
		uop = mkUop(op, nop, none);

		////////////////////////////////////////
		// Register families
		////////////////////////////////////////
		if (uAddr >= flowLdRn && uAddr < flowLdRn + 8'd28)
		begin
			// LD r,n: step past opcode, address immediate, load it
			off = uAddr - flowLdRn;
			fReg = regSel_t'({2'b00, off[4:2]});
			case (off[1:0])
				2'd0: uop = mkUop(inc, nop, none);
				2'd1: uop = mkUop(op, sma, pc);
				2'd2: uop = mkUop(incEof, srm, fReg);
				default: uop = mkUop(op, nop, none);
			endcase
		end
		else if (uAddr >= flowAddR && uAddr < flowAddR + 8'd28)
		begin
			// ADD A,r through the scratch register
			off = uAddr - flowAddR;
			fReg = regSel_t'({2'b00, off[4:2]});
			case (off[1:0])
				2'd0: uop = mkUop(op, sx16r, a);
				2'd1: uop = mkUop(op, addx16, fReg);
				2'd2: uop = mkUop(incEof, srx16, a);
				default: uop = mkUop(op, nop, none);
			endcase
		end
		else if (uAddr >= flowSubR && uAddr < flowSubR + 8'd28)
		begin
			// SUB r, same shape
			off = uAddr - flowSubR;
			fReg = regSel_t'({2'b00, off[4:2]});
			case (off[1:0])
				2'd0: uop = mkUop(op, sx16r, a);
				2'd1: uop = mkUop(op, subx16, fReg);
				2'd2: uop = mkUop(incEof, srx16, a);
				default: uop = mkUop(op, nop, none);
			endcase
		end
		else if (uAddr >= flowIncR && uAddr < flowIncR + 8'd7)
		begin
			off = uAddr - flowIncR;
			uop = mkUop(incEof, inc16, regSel_t'(off[4:0]));
		end
		else if (uAddr >= flowDecR && uAddr < flowDecR + 8'd7)
		begin
			off = uAddr - flowDecR;
			uop = mkUop(incEof, dec16, regSel_t'(off[4:0]));
		end
		else
		begin
			////////////////////////////////////////
			// Single flows
			////////////////////////////////////////
			case (uAddr)
				// NOP, also any unknown opcode
				flowNop: uop = mkUop(incEof, nop, none);
				// LD HL,nn, low byte first
				flowLdHlNn: uop = mkUop(inc, nop, none);
				flowLdHlNn + 8'd1: uop = mkUop(inc, srm, l);
				flowLdHlNn + 8'd2: uop = mkUop(incEof, srm, h);
				// LD (HL),A
				flowLdHlA: uop = mkUop(op, sma, hl);
				flowLdHlA + 8'd1: uop = mkUop(op, smw, a);
				flowLdHlA + 8'd2: uop = mkUop(incEof, nop, none);
				// LD A,(HL)
				flowLdAHl: uop = mkUop(op, sma, hl);
				flowLdAHl + 8'd1: uop = mkUop(incEof, srm, a);
				// JR n
				flowJr: uop = mkUop(inc, nop, none);
				flowJr + 8'd1: uop = mkUop(op, sma, pc);
				flowJr + 8'd2: uop = mkUop(inc, srm, x8);
				flowJr + 8'd3: uop = mkUop(op, sx16r, pc);
				flowJr + 8'd4: uop = mkUop(op, addx16, x8);
				flowJr + 8'd5: uop = mkUop(eof, spc, x16);
				// JR NZ, leaves at the offset byte when Z is set
				flowJrNz: uop = mkUop(inc, nop, none);
				flowJrNz + 8'd1: uop = mkUop(op, sma, pc);
				flowJrNz + 8'd2: uop = mkUop(incEofZ, srm, x8);
				flowJrNz + 8'd3: uop = mkUop(op, sx16r, pc);
				flowJrNz + 8'd4: uop = mkUop(op, addx16, x8);
				flowJrNz + 8'd5: uop = mkUop(eof, spc, x16);
				// JR Z
				flowJrZ: uop = mkUop(inc, nop, none);
				flowJrZ + 8'd1: uop = mkUop(op, sma, pc);
				flowJrZ + 8'd2: uop = mkUop(incEofNz, srm, x8);
				flowJrZ + 8'd3: uop = mkUop(op, sx16r, pc);
				flowJrZ + 8'd4: uop = mkUop(op, addx16, x8);
				flowJrZ + 8'd5: uop = mkUop(eof, spc, x16);
				// JP nn, both bytes shifted into scratch
				flowJp: uop = mkUop(inc, nop, none);
				flowJp + 8'd1: uop = mkUop(inc, srm, x16);
				flowJp + 8'd2: uop = mkUop(op, srm, x16);
				flowJp + 8'd3: uop = mkUop(eof, spc, x16);
				// CB prefix, second byte goes to the CB table
				flowCb: uop = mkUop(inc, nop, none);
				flowCb + 8'd1: uop = mkUop(jumpCb, nop, none);
				flowBit7H: uop = mkUop(incEof, bitTest, h);
				default: uop = mkUop(op, nop, none);
			endcase
		end
	end

endmodule

/* ucodeLut.sv */
`timescale 1ns/10ps

module ucodeLut
	import cpuOpcodePkg::*;
(
	input logic [7:0] mop,
	input logic cbMode,
	output logic [7:0] flowIdx
);

	always_comb
	begin
		flowIdx = flowNop;
		if (cbMode)
		begin
			// CB table, only BIT 7,H is kept
			case (mop)
				opBit7H: flowIdx = flowBit7H;
				default: flowIdx = flowNop;
			endcase
		end
		else
		begin
			case (mop)
				opNop: flowIdx = flowNop;
				// Immediate loads, stride 4
				opLdAn: flowIdx = flowLdRn;
				opLdBn: flowIdx = flowLdRn + 8'd4;
				opLdCn: flowIdx = flowLdRn + 8'd8;
				opLdDn: flowIdx = flowLdRn + 8'd12;
				opLdEn: flowIdx = flowLdRn + 8'd16;
				opLdHn: flowIdx = flowLdRn + 8'd20;
				opLdLn: flowIdx = flowLdRn + 8'd24;
				// Single micro-op INC
				opIncA: flowIdx = flowIncR;
				opIncB: flowIdx = flowIncR + 8'd1;
				opIncC: flowIdx = flowIncR + 8'd2;
				opIncD: flowIdx = flowIncR + 8'd3;
				opIncE: flowIdx = flowIncR + 8'd4;
				opIncH: flowIdx = flowIncR + 8'd5;
				opIncL: flowIdx = flowIncR + 8'd6;
				// Single micro-op DEC
				opDecA: flowIdx = flowDecR;
				opDecB: flowIdx = flowDecR + 8'd1;
				opDecC: flowIdx = flowDecR + 8'd2;
				opDecD: flowIdx = flowDecR + 8'd3;
				opDecE: flowIdx = flowDecR + 8'd4;
				opDecH: flowIdx = flowDecR + 8'd5;
				opDecL: flowIdx = flowDecR + 8'd6;
				// ALU flows
				opAddAA: flowIdx = flowAddR;
				opAddAB: flowIdx = flowAddR + 8'd4;
				opAddAC: flowIdx = flowAddR + 8'd8;
				opAddAD: flowIdx = flowAddR + 8'd12;
				opAddAE: flowIdx = flowAddR + 8'd16;
				opAddAH: flowIdx = flowAddR + 8'd20;
				opAddAL: flowIdx = flowAddR + 8'd24;
				opSubA: flowIdx = flowSubR;
				opSubB: flowIdx = flowSubR + 8'd4;
				opSubC: flowIdx = flowSubR + 8'd8;
				opSubD: flowIdx = flowSubR + 8'd12;
				opSubE: flowIdx = flowSubR + 8'd16;
				opSubH: flowIdx = flowSubR + 8'd20;
				opSubL: flowIdx = flowSubR + 8'd24;
				// Everything else
				opLdHlNn: flowIdx = flowLdHlNn;
				opLdHlA: flowIdx = flowLdHlA;
				opLdAHl: flowIdx = flowLdAHl;
				opJr: flowIdx = flowJr;
				opJrNz: flowIdx = flowJrNz;
				opJrZ: flowIdx = flowJrZ;
				opJpNn: flowIdx = flowJp;
				opPrefixCb: flowIdx = flowCb;
				default: flowIdx = flowNop;
			endcase
		end
	end

endmodule

/* cpuUopPkg.sv */
package cpuUopPkg;

	////////////////////////////////////////
	// Micro-program addressing
	////////////////////////////////////////

	localparam int uopAddrW = 8;
	// Parked address while waiting after reset, outside every flow
	localparam logic [uopAddrW-1:0] uPcIdle = 8'hFF;

	////////////////////////////////////////
	// Micro-op fields
	////////////////////////////////////////

	// Sequencing action, PC advance folded in
	typedef enum logic [2:0]
	{
		op,
		inc,
		eof,
		incEof,
		incEofZ,
		incEofNz,
		jumpCb
	} seqAct_t;

	// Operation on the operand
	typedef enum logic [4:0]
	{
		nop,
		sma,
		smw,
		srm,
		sx16r,
		srx16,
		addx16,
		subx16,
		inc16,
		dec16,
		spc,
		bitTest
	} uopOp_t;

	// Operand select, 8-bit registers first so the low bits index the file
	typedef enum logic [4:0]
	{
		a,
		b,
		c,
		d,
		e,
		h,
		l,
		hl,
		de,
		pc,
		x8,
		x16,
		none
	} regSel_t;

	// 13-bit micro-op word
	typedef struct packed
	{
		seqAct_t act;
		uopOp_t oper;
		regSel_t sel;
	} uop_t;

	// Memory bus outputs
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0] wData;
		logic wEn;
	} memBus_t;

endpackage

/* cpuOpcodePkg.sv */
package cpuOpcodePkg;

	////////////////////////////////////////
	// Opcode bytes
	////////////////////////////////////////

	localparam logic [7:0] opNop = 8'h00;

	// LD r,n
	localparam logic [7:0] opLdAn = 8'h3E;
	localparam logic [7:0] opLdBn = 8'h06;
	localparam logic [7:0] opLdCn = 8'h0E;
	localparam logic [7:0] opLdDn = 8'h16;
	localparam logic [7:0] opLdEn = 8'h1E;
	localparam logic [7:0] opLdHn = 8'h26;
	localparam logic [7:0] opLdLn = 8'h2E;

	// INC r
	localparam logic [7:0] opIncA = 8'h3C;
	localparam logic [7:0] opIncB = 8'h04;
	localparam logic [7:0] opIncC = 8'h0C;
	localparam logic [7:0] opIncD = 8'h14;
	localparam logic [7:0] opIncE = 8'h1C;
	localparam logic [7:0] opIncH = 8'h24;
	localparam logic [7:0] opIncL = 8'h2C;

	// DEC r
	localparam logic [7:0] opDecA = 8'h3D;
	localparam logic [7:0] opDecB = 8'h05;
	localparam logic [7:0] opDecC = 8'h0D;
	localparam logic [7:0] opDecD = 8'h15;
	localparam logic [7:0] opDecE = 8'h1D;
	localparam logic [7:0] opDecH = 8'h25;
	localparam logic [7:0] opDecL = 8'h2D;

	// ADD A,r
	localparam logic [7:0] opAddAA = 8'h87;
	localparam logic [7:0] opAddAB = 8'h80;
	localparam logic [7:0] opAddAC = 8'h81;
	localparam logic [7:0] opAddAD = 8'h82;
	localparam logic [7:0] opAddAE = 8'h83;
	localparam logic [7:0] opAddAH = 8'h84;
	localparam logic [7:0] opAddAL = 8'h85;

	// SUB r
	localparam logic [7:0] opSubA = 8'h97;
	localparam logic [7:0] opSubB = 8'h90;
	localparam logic [7:0] opSubC = 8'h91;
	localparam logic [7:0] opSubD = 8'h92;
	localparam logic [7:0] opSubE = 8'h93;
	localparam logic [7:0] opSubH = 8'h94;
	localparam logic [7:0] opSubL = 8'h95;

	// Loads through HL and control flow
	localparam logic [7:0] opLdHlNn = 8'h21;
	localparam logic [7:0] opLdHlA = 8'h77;
	localparam logic [7:0] opLdAHl = 8'h7E;
	localparam logic [7:0] opJr = 8'h18;
	localparam logic [7:0] opJrNz = 8'h20;
	localparam logic [7:0] opJrZ = 8'h28;
	localparam logic [7:0] opJpNn = 8'hC3;
	localparam logic [7:0] opPrefixCb = 8'hCB;
	// Second byte after the CB prefix
	localparam logic [7:0] opBit7H = 8'h7C;

	////////////////////////////////////////
	// Micro-flow start indices
	////////////////////////////////////////

	// Flow 0 doubles as the unknown opcode flow
	localparam logic [7:0] flowNop = 8'd0;
	localparam logic [7:0] flowLdHlNn = 8'd1;
	localparam logic [7:0] flowLdHlA = 8'd4;
	localparam logic [7:0] flowLdAHl = 8'd7;
	localparam logic [7:0] flowJr = 8'd9;
	localparam logic [7:0] flowJrNz = 8'd15;
	localparam logic [7:0] flowJrZ = 8'd21;
	localparam logic [7:0] flowJp = 8'd27;
	localparam logic [7:0] flowCb = 8'd31;
	localparam logic [7:0] flowBit7H = 8'd33;
	// One micro-op per register, order A B C D E H L
	localparam logic [7:0] flowIncR = 8'd34;
	localparam logic [7:0] flowDecR = 8'd41;
	// Four slots per register, same order
	localparam logic [7:0] flowLdRn = 8'd48;
	localparam logic [7:0] flowAddR = 8'd80;
	localparam logic [7:0] flowSubR = 8'd112;

endpackage
